/* Makefile */
TOP := mem_stage_tb

.PHONY: all lint clean

# Build, run, and pass only when the pass line is printed.
all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

obj_dir/V$(TOP): verilog.f $(wildcard source/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

/* source/data_ram_banked.sv */
`timescale 1ns/1ps

module data_ram_banked #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                             i_clk,
   mem_port_if.ram                          i_port,
   output logic [mem_stage_pkg::DATA_W-1:0] o_rd_word
);

   // Word address bits and the words they reach.
   localparam int WORD_AW = ADDR_WIDTH - mem_stage_pkg::OFFS_W;
   localparam int DEPTH   = 1 << WORD_AW;

   ////////////////////////////////////////////////////////////////////////////
   // Byte banks, one per lane.
   ////////////////////////////////////////////////////////////////////////////

   for (genvar lane = 0; lane < mem_stage_pkg::LANES; lane++) begin : g_lane

      logic [mem_stage_pkg::BYTE_W-1:0] bank [DEPTH];

      // Write this lane when its enable is set.
      always_ff @(posedge i_clk) begin
         if (i_port.wr_en[lane]) begin
            bank[i_port.word_addr] <=
               i_port.wr_data[lane*mem_stage_pkg::BYTE_W +: mem_stage_pkg::BYTE_W];
         end
      end

      // Registered read, holds its value between reads.
      always_ff @(posedge i_clk) begin
         if (i_port.rd_en) begin
            o_rd_word[lane*mem_stage_pkg::BYTE_W +: mem_stage_pkg::BYTE_W] <=
               bank[i_port.word_addr];
         end
      end

   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks.
   ////////////////////////////////////////////////////////////////////////////

   // The aligner must never hand over a read and a write in one cycle.
   a_no_rd_wr_overlap : assert property (
      @(posedge i_clk) !(i_port.rd_en && (|i_port.wr_en))
   ) else $error("data_ram_banked: read and write in the same cycle");

endmodule

/* source/load_extend.sv */
`timescale 1ns/1ps

module load_extend (
   input  logic                             i_clk,
   input  logic                             i_rst_n,
   input  logic                             i_read_mem,
   input  logic [mem_stage_pkg::SEL_W-1:0]  i_sel,
   input  logic [mem_stage_pkg::OFFS_W-1:0] i_offs,
   input  logic [mem_stage_pkg::DATA_W-1:0] i_rd_word,
   output logic [mem_stage_pkg::DATA_W-1:0] o_load_data,
   output logic                             o_load_valid
);

   localparam int HALF_W = 2 * mem_stage_pkg::BYTE_W;

   logic                                   rd_q;
   logic [mem_stage_pkg::SEL_W-1:0]        sel_q;
   logic [mem_stage_pkg::OFFS_W-1:0]       offs_q;
   logic [mem_stage_pkg::SEL_UNSIGNED-1:0] size_q;
   logic                                   uns_q;
   logic [mem_stage_pkg::BYTE_W-1:0]       byte_val;
   logic [HALF_W-1:0]                      half_val;

   ////////////////////////////////////////////////////////////////////////////
   // Request stage, in step with the RAM read.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         rd_q   <= 1'b0;
         sel_q  <= '0;
         offs_q <= '0;
      end else begin
         rd_q   <= i_read_mem;
         sel_q  <= i_sel;
         offs_q <= i_offs;
      end
   end

   assign size_q = sel_q[mem_stage_pkg::SEL_UNSIGNED-1:0];
   assign uns_q  = sel_q[mem_stage_pkg::SEL_UNSIGNED];

   ////////////////////////////////////////////////////////////////////////////
   // Extract and extend.
   ////////////////////////////////////////////////////////////////////////////

   assign byte_val = i_rd_word[offs_q*mem_stage_pkg::BYTE_W +: mem_stage_pkg::BYTE_W];
   assign half_val = i_rd_word[offs_q[1]*HALF_W +: HALF_W];   // Offset bit 0 ignored.

   always_comb begin
      case (size_q)
         mem_stage_pkg::SIZE_BYTE: begin
            o_load_data = {{(mem_stage_pkg::DATA_W-mem_stage_pkg::BYTE_W)
                             {~uns_q & byte_val[mem_stage_pkg::BYTE_W-1]}}, byte_val};
         end
         mem_stage_pkg::SIZE_HALF: begin
            o_load_data = {{(mem_stage_pkg::DATA_W-HALF_W){~uns_q & half_val[HALF_W-1]}},
                           half_val};
         end
         mem_stage_pkg::SIZE_WORD: begin
            o_load_data = i_rd_word;
         end
         default: begin
            o_load_data = '0;   // Size 0.
         end
      endcase
   end

   assign o_load_valid = rd_q;

   // Valid only ever follows a read issued one cycle earlier.
   a_valid_follows_read : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) o_load_valid |-> $past(i_read_mem)
   ) else $error("load_extend: load valid without a preceding read");

endmodule

/* source/mem_port_if.sv */
`timescale 1ns/1ps

// One cycle's access from the store aligner to the data RAM.
interface mem_port_if #(
   parameter int ADDR_WIDTH = 10
);

   ////////////////////////////////////////////////////////////////////////////
   // Access signals.
   ////////////////////////////////////////////////////////////////////////////

   logic [ADDR_WIDTH-mem_stage_pkg::OFFS_W-1:0] word_addr;   // Word, not byte.
   logic [mem_stage_pkg::LANES-1:0]              wr_en;       // Per-lane write.
   logic [mem_stage_pkg::DATA_W-1:0]             wr_data;     // Already lane aligned.
   logic                                         rd_en;       // Read strobe.

   ////////////////////////////////////////////////////////////////////////////
   // Views.
   ////////////////////////////////////////////////////////////////////////////

   // Store aligner side.
   modport align (
      output word_addr, wr_en, wr_data, rd_en
   );

   // RAM side.
   modport ram (
      input word_addr, wr_en, wr_data, rd_en
   );

endinterface

/* source/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                             i_clk,
   input  logic                             i_rst_n,
   input  logic [mem_stage_pkg::SEL_W-1:0]  i_sel,
   input  logic                             i_write_mem,
   input  logic                             i_read_mem,
   input  logic [ADDR_WIDTH-1:0]            i_addr,
   input  logic [mem_stage_pkg::DATA_W-1:0] i_wr_data,
   output logic [mem_stage_pkg::DATA_W-1:0] o_load_data,
   output logic                             o_load_valid
);

   logic [mem_stage_pkg::DATA_W-1:0] rd_word;   // Raw RAM word, one cycle late.

   ////////////////////////////////////////////////////////////////////////////
   // Store side.
   ////////////////////////////////////////////////////////////////////////////

   mem_port_if #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) mem_port_i ();

   store_lane_align #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) store_lane_align_i (
      .i_sel       (i_sel),
      .i_write_mem (i_write_mem),
      .i_read_mem  (i_read_mem),
      .i_addr      (i_addr),
      .i_data      (i_wr_data),
      .o_port      (mem_port_i)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Storage.
   ////////////////////////////////////////////////////////////////////////////

   data_ram_banked #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) data_ram_banked_i (
      .i_clk     (i_clk),
      .i_port    (mem_port_i),
      .o_rd_word (rd_word)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Load side.
   ////////////////////////////////////////////////////////////////////////////

   load_extend load_extend_i (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_read_mem   (i_read_mem),
      .i_sel        (i_sel),
      .i_offs       (i_addr[mem_stage_pkg::OFFS_W-1:0]),   // Byte offset only.
      .i_rd_word    (rd_word),
      .o_load_data  (o_load_data),
      .o_load_valid (o_load_valid)
   );

endmodule

/* source/mem_stage_pkg.sv */
package mem_stage_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data path geometry.
   ////////////////////////////////////////////////////////////////////////////

   // Full data word.
   parameter int DATA_W = 32;

   // One byte lane.
   parameter int BYTE_W = 8;

   // Lanes per word, four for a 32-bit word.
   parameter int LANES = DATA_W / BYTE_W;

   // Byte offset bits inside a word.
   parameter int OFFS_W = $clog2(LANES);

   ////////////////////////////////////////////////////////////////////////////
   // Access select encoding.
   ////////////////////////////////////////////////////////////////////////////

   // Select word width.
   parameter int SEL_W = 3;

   // Top select bit marks an unsigned load.
   parameter int SEL_UNSIGNED = 2;

   // Size codes in the low select bits.
   parameter logic [SEL_UNSIGNED-1:0] SIZE_NONE = 2'd0;   // No access.
   parameter logic [SEL_UNSIGNED-1:0] SIZE_BYTE = 2'd1;   // Byte.
   parameter logic [SEL_UNSIGNED-1:0] SIZE_HALF = 2'd2;   // Halfword.
   parameter logic [SEL_UNSIGNED-1:0] SIZE_WORD = 2'd3;   // Word.

endpackage

/* source/store_lane_align.sv */
`timescale 1ns/1ps

module store_lane_align #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic [mem_stage_pkg::SEL_W-1:0]  i_sel,
   input  logic                             i_write_mem,
   input  logic                             i_read_mem,
   input  logic [ADDR_WIDTH-1:0]            i_addr,
   input  logic [mem_stage_pkg::DATA_W-1:0] i_data,
   mem_port_if.align                        o_port
);

   // Lane masks for the fixed four-lane word.
   localparam logic [mem_stage_pkg::LANES-1:0] LANE_ONE = 1;
   localparam logic [mem_stage_pkg::LANES-1:0] HALF_HI  = 4'b1100;
   localparam logic [mem_stage_pkg::LANES-1:0] HALF_LO  = 4'b0011;

   logic [mem_stage_pkg::SEL_UNSIGNED-1:0] size;
   logic [mem_stage_pkg::OFFS_W-1:0]       offs;
   logic [mem_stage_pkg::LANES-1:0]        lane_en;
   logic [mem_stage_pkg::DATA_W-1:0]       lane_data;

   assign size = i_sel[mem_stage_pkg::SEL_UNSIGNED-1:0];   // Unsigned bit plays no part here.
   assign offs = i_addr[mem_stage_pkg::OFFS_W-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // Lane decode.
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      lane_en   = '0;
      lane_data = i_data;
      if (i_read_mem) begin
         // Read wins over a simultaneous write.
         lane_en = '0;
      end else if (i_write_mem) begin
         case (size)
            mem_stage_pkg::SIZE_WORD: begin
               lane_en = '1;
            end
            mem_stage_pkg::SIZE_HALF: begin
               // Only address bit 1 picks the half.
               if (offs[1]) begin
                  lane_en   = HALF_HI;
                  lane_data = i_data << (2 * mem_stage_pkg::BYTE_W);
               end else begin
                  lane_en = HALF_LO;
               end
            end
            mem_stage_pkg::SIZE_BYTE: begin
               lane_en   = LANE_ONE << offs;
               lane_data = i_data << (mem_stage_pkg::BYTE_W * offs);
            end
            mem_stage_pkg::SIZE_NONE: begin
               lane_en = '0;   // Nothing to store.
            end
            default: begin
               lane_en = '0;
            end
         endcase
      end

      // Checks on the decoded enables.
      if (i_read_mem) begin
         assert (lane_en == '0)
            else $error("store_lane_align: lanes enabled during a read");
      end else if (i_write_mem && size == mem_stage_pkg::SIZE_BYTE) begin
         assert ($onehot(lane_en))
            else $error("store_lane_align: byte store enables %b", lane_en);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Port drive.
   ////////////////////////////////////////////////////////////////////////////

   assign o_port.word_addr = i_addr[ADDR_WIDTH-1:mem_stage_pkg::OFFS_W];
   assign o_port.wr_en     = lane_en;
   assign o_port.wr_data   = lane_data;
   assign o_port.rd_en     = i_read_mem;   // Address passes through either way.

endmodule

/* test/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

   localparam int ADDR_W    = 10;   // Matches the DUT default.
   localparam int WORD_AW   = ADDR_W - mem_stage_pkg::OFFS_W;
   localparam int MEM_BYTES = 1 << ADDR_W;
   localparam int WORDS     = 1 << WORD_AW;

   localparam logic [mem_stage_pkg::SEL_W-1:0] SEL_NONE = {1'b0, mem_stage_pkg::SIZE_NONE};
   localparam logic [mem_stage_pkg::SEL_W-1:0] SEL_BYTE = {1'b0, mem_stage_pkg::SIZE_BYTE};
   localparam logic [mem_stage_pkg::SEL_W-1:0] SEL_HALF = {1'b0, mem_stage_pkg::SIZE_HALF};
   localparam logic [mem_stage_pkg::SEL_W-1:0] SEL_WORD = {1'b0, mem_stage_pkg::SIZE_WORD};

   // Operations per test, for the watchdog.
   localparam int FILL_OPS  = WORDS;
   localparam int WORD_OPS  = 16 * 2;
   localparam int BYTE_OPS  = 8 * 4 * 2;
   localparam int HALF_OPS  = 8 * 4 * 2;
   localparam int EXT_OPS   = 8 * 17;
   localparam int GUARD_OPS = 4 * 6;
   localparam int B2B_OPS   = 8 * 3 + 2;
   localparam int NUM_OPS   = FILL_OPS + WORD_OPS + BYTE_OPS + HALF_OPS + EXT_OPS
                              + GUARD_OPS + B2B_OPS;

   logic                             clk;
   logic                             rst_n;
   logic [mem_stage_pkg::SEL_W-1:0]  sel;
   logic                             write_mem;
   logic                             read_mem;
   logic [ADDR_W-1:0]                addr;
   logic [mem_stage_pkg::DATA_W-1:0] wr_data;
   logic [mem_stage_pkg::DATA_W-1:0] load_data;
   logic                             load_valid;

   logic [mem_stage_pkg::BYTE_W-1:0] model_mem [MEM_BYTES];   // Byte addressed.

   tb_clock_gen #(
      .PERIOD_NS    (8),
      .RESET_CYCLES (8)
   ) tb_clock_gen_i (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   mem_stage mem_stage_i (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .i_sel        (sel),
      .i_write_mem  (write_mem),
      .i_read_mem   (read_mem),
      .i_addr       (addr),
      .i_wr_data    (wr_data),
      .o_load_data  (load_data),
      .o_load_valid (load_valid)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and helpers.
   ////////////////////////////////////////////////////////////////////////////

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "testbench stopped on error");
   endtask

   function automatic logic [ADDR_W-1:0] random_addr(input logic aligned);
      logic [31:0] r;
      r = $urandom;
      if (aligned) begin
         r[1:0] = 2'b00;
      end
      return r[ADDR_W-1:0];
   endfunction

   // Memory update by the lane rules.
   function automatic void model_store(input logic [2:0] s, input logic [ADDR_W-1:0] a,
                                       input logic [31:0] d);
      logic [ADDR_W-1:0] base;
      logic [ADDR_W-1:0] lo;
      base = {a[ADDR_W-1:2], 2'b00};
      lo   = {a[ADDR_W-1:2], a[1], 1'b0};   // Bit 0 ignored for halves.
      case (s[1:0])
         mem_stage_pkg::SIZE_WORD: begin
            for (int i = 0; i < 4; i++) begin
               model_mem[base + i] = d[8*i +: 8];
            end
         end
         mem_stage_pkg::SIZE_HALF: begin
            model_mem[lo]     = d[7:0];
            model_mem[lo + 1] = d[15:8];
         end
         mem_stage_pkg::SIZE_BYTE: model_mem[a] = d[7:0];
         default: ;   // Size 0 stores nothing.
      endcase
   endfunction

   function automatic logic [31:0] expected_load(input logic [2:0] s,
                                                 input logic [ADDR_W-1:0] a);
      logic [ADDR_W-1:0] base;
      logic [ADDR_W-1:0] lo;
      logic [7:0]        b;
      logic [15:0]       h;
      base = {a[ADDR_W-1:2], 2'b00};
      lo   = {a[ADDR_W-1:2], a[1], 1'b0};
      b    = model_mem[a];
      h    = {model_mem[lo + 1], model_mem[lo]};
      case (s[1:0])
         mem_stage_pkg::SIZE_BYTE: return s[2] ? {24'h0, b} : {{24{b[7]}}, b};
         mem_stage_pkg::SIZE_HALF: return s[2] ? {16'h0, h} : {{16{h[15]}}, h};
         mem_stage_pkg::SIZE_WORD: begin
            return {model_mem[base + 3], model_mem[base + 2],
                    model_mem[base + 1], model_mem[base]};
         end
         default: return '0;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Drive and check.
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive(input logic w, input logic r, input logic [2:0] s,
                        input logic [ADDR_W-1:0] a, input logic [31:0] d);
      @(posedge clk);
      write_mem <= w;
      read_mem  <= r;
      sel       <= s;
      addr      <= a;
      wr_data   <= d;
   endtask

   task automatic go_idle();
      drive(1'b0, 1'b0, SEL_NONE, '0, '0);
   endtask

   task automatic store(input logic [2:0] s, input logic [ADDR_W-1:0] a,
                        input logic [31:0] d);
      drive(1'b1, 1'b0, s, a, d);
      model_store(s, a, d);
   endtask

   // Sampled mid-cycle, well clear of the edge.
   task automatic check_load(input string what, input logic [31:0] exp);
      @(negedge clk);
      assert (load_valid === 1'b1)
         else fail_run($sformatf("FAILED at %0t: %s, load valid is %b", $time, what,
                                 load_valid));
      assert (load_data === exp)
         else fail_run($sformatf("FAILED at %0t: %s, expected %08h, got %08h", $time,
                                 what, exp, load_data));
   endtask

   task automatic check_no_valid(input string what);
      @(negedge clk);
      assert (load_valid === 1'b0)
         else fail_run($sformatf("FAILED at %0t: load valid is %b %s", $time, load_valid,
                                 what));
   endtask

   task automatic load_and_check(input logic [2:0] s, input logic [ADDR_W-1:0] a);
      logic [31:0] exp;
      exp = expected_load(s, a);
      drive(1'b0, 1'b1, s, a, $urandom);
      go_idle();
      check_load($sformatf("load sel %b addr %03h", s, a), exp);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests.
   ////////////////////////////////////////////////////////////////////////////

   task automatic fill_memory();
      for (int w = 0; w < WORDS; w++) begin
         store(SEL_WORD, {w[WORD_AW-1:0], 2'b00}, $urandom);
      end
      go_idle();
   endtask

   task automatic word_store_load_test();
      logic [ADDR_W-1:0] a;
      for (int i = 0; i < 16; i++) begin
         a = random_addr(1'b1);
         store(SEL_WORD, a, $urandom);
         load_and_check(SEL_WORD, a);
      end
   endtask

   // Offsets 1 and 3 on halves check that bit 0 is ignored.
   task automatic sub_word_store_test(input logic [2:0] s);
      logic [ADDR_W-1:0] a;
      for (int i = 0; i < 8; i++) begin
         a = random_addr(1'b1);
         for (int off = 0; off < 4; off++) begin
            a[1:0] = off[1:0];
            store(s, a, $urandom);
            load_and_check(SEL_WORD, a);
         end
      end
   endtask

   task automatic extend_test();
      logic [ADDR_W-1:0] a;
      logic [31:0]       d;
      for (int i = 0; i < 8; i++) begin
         a = random_addr(1'b1);
         d = $urandom;
         d = i[0] ? (d & 32'h7f7f7f7f) : (d | 32'h80808080);   // Top bits clear or set.
         store(SEL_WORD, a, d);
         for (int off = 0; off < 4; off++) begin
            a[1:0] = off[1:0];
            for (int u = 0; u < 2; u++) begin
               load_and_check({u[0], mem_stage_pkg::SIZE_BYTE}, a);
               load_and_check({u[0], mem_stage_pkg::SIZE_HALF}, a);
            end
         end
      end
   endtask

   task automatic guard_test();
      logic [ADDR_W-1:0] a;
      logic [31:0]       exp;
      for (int i = 0; i < 4; i++) begin
         a   = random_addr(1'b1);
         exp = expected_load(SEL_WORD, a);
         drive(1'b1, 1'b1, SEL_WORD, a, ~exp);   // Read wins.
         go_idle();
         check_load("load with write also high", exp);
         load_and_check(SEL_WORD, a);
         store(SEL_NONE, a, ~exp);
         load_and_check(SEL_WORD, a);
         load_and_check(SEL_NONE, a);
         load_and_check(SEL_NONE | 3'b100, a);
      end
   endtask

   task automatic back_to_back_test();
      logic [ADDR_W-1:0] a1;
      logic [ADDR_W-1:0] a2;
      logic [31:0]       r;
      logic [31:0]       e1;
      logic [31:0]       e2;
      store(SEL_HALF, random_addr(1'b0), $urandom);
      go_idle();
      check_no_valid("after a store");
      for (int i = 0; i < 8; i++) begin
         a1 = random_addr(1'b0);
         a2 = random_addr(1'b0);
         r  = $urandom;
         e1 = expected_load(r[2:0], a1);
         e2 = expected_load(r[5:3], a2);
         drive(1'b0, 1'b1, r[2:0], a1, '0);
         drive(1'b0, 1'b1, r[5:3], a2, '0);
         check_load($sformatf("first of two loads, addr %03h", a1), e1);
         go_idle();
         check_load($sformatf("second of two loads, addr %03h", a2), e2);
         check_no_valid("in a cycle after no read");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence and watchdog.
   ////////////////////////////////////////////////////////////////////////////

   initial begin : main
      void'($urandom(32'h73ee5cbb));
      sel       = SEL_WORD;
      write_mem = 1'b0;
      read_mem  = 1'b1;   // A read pending through reset must not show as valid.
      addr      = '0;
      wr_data   = '0;
      wait (rst_n === 1'b1);
      sel      <= SEL_NONE;
      read_mem <= 1'b0;
      check_no_valid("after reset");
      fill_memory();
      word_store_load_test();
      sub_word_store_test(SEL_BYTE);
      sub_word_store_test(SEL_HALF);
      extend_test();
      guard_test();
      back_to_back_test();
      $display("STATUS: PASS");
      $finish;
   end

   initial begin : watchdog
      repeat (8 + NUM_OPS * 10) @(posedge clk);
      fail_run($sformatf("Timeout: the tests did not finish within %0d clock cycles",
                         8 + NUM_OPS * 10));
   end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic o_clk,
   output logic o_rst_n
);

   initial begin
      o_clk = 1'b0;
   end

   always #(PERIOD_NS / 2) o_clk = ~o_clk;

   // Reset held low, released on a rising edge.
   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_rst_n <= 1'b1;
   end

endmodule

/* verilog.f */
source/mem_stage_pkg.sv
source/mem_port_if.sv
source/store_lane_align.sv
source/data_ram_banked.sv
source/load_extend.sv
source/mem_stage.sv
test/tb_clock_gen.sv
test/mem_stage_tb.sv
